//--- hdl/arm_dp_pkg.sv
`default_nettype none

package arm_dp_pkg;

	localparam int word_w = 32;
	localparam int reg_w = 4;

	localparam logic [reg_w-1:0] r15 = 4'd15;

	localparam logic [3:0] alu_and = 4'b0000;
	localparam logic [3:0] alu_eor = 4'b0001;
	localparam logic [3:0] alu_sub = 4'b0010;
	localparam logic [3:0] alu_rsb = 4'b0011;
	localparam logic [3:0] alu_add = 4'b0100;
	localparam logic [3:0] alu_adc = 4'b0101;
	localparam logic [3:0] alu_sbc = 4'b0110;
	localparam logic [3:0] alu_rsc = 4'b0111;
	localparam logic [3:0] alu_tst = 4'b1000;
	localparam logic [3:0] alu_teq = 4'b1001;
	localparam logic [3:0] alu_cmp = 4'b1010;
	localparam logic [3:0] alu_cmn = 4'b1011;
	localparam logic [3:0] alu_orr = 4'b1100;
	localparam logic [3:0] alu_mov = 4'b1101;
	localparam logic [3:0] alu_bic = 4'b1110;
	localparam logic [3:0] alu_mvn = 4'b1111;

	localparam logic [1:0] shift_lsl = 2'b00;
	localparam logic [1:0] shift_lsr = 2'b01;
	localparam logic [1:0] shift_asr = 2'b10;
	localparam logic [1:0] shift_ror = 2'b11;

	// The I bit picks which of the two views holds the second operand.
	typedef union packed {
		struct packed {
			logic [3:0]       cond;
			logic [1:0]       insn_class;
			logic             imm_bit;
			logic [3:0]       opcode;
			logic             s_bit;
			logic [reg_w-1:0] rn;
			logic [reg_w-1:0] rd;
			logic [3:0]       rotate;
			logic [7:0]       imm8;
		} imm_form;
		struct packed {
			logic [3:0]       cond;
			logic [1:0]       insn_class;
			logic             imm_bit;
			logic [3:0]       opcode;
			logic             s_bit;
			logic [reg_w-1:0] rn;
			logic [reg_w-1:0] rd;
			logic [3:0]       shift_hi; // Rs, or the top four bits of the shift amount.
			logic             zero_bit;
			logic [1:0]       shift_type;
			logic             by_reg;
			logic [reg_w-1:0] rm;
		} reg_form;
	} dp_insn_u;

endpackage

`default_nettype wire

//--- hdl/dp_decode.sv
`timescale 1ns/1ns
`default_nettype none

module dp_decode (
	input  arm_dp_pkg::dp_insn_u         insn,
	output logic [3:0]                   op,
	output logic [arm_dp_pkg::reg_w-1:0] rn,
	output logic [arm_dp_pkg::reg_w-1:0] rd,
	output logic [arm_dp_pkg::reg_w-1:0] rm,
	output logic [arm_dp_pkg::reg_w-1:0] rs,
	output logic                         snd_is_imm,
	output logic                         snd_shift_by_reg,
	output logic [7:0]                   imm8,
	output logic [5:0]                   shift_imm,
	output logic                         shl,
	output logic                         shr,
	output logic                         ror,
	output logic                         put_carry,
	output logic                         sign_extend,
	output logic                         writeback,
	output logic                         update_flags,
	output logic                         restore_spsr,
	output logic                         undefined
);

	logic [1:0] shift_type;
	logic [4:0] shift_field;

	assign op = insn.imm_form.opcode;
	assign rn = insn.imm_form.rn;
	assign rd = insn.imm_form.rd;
	assign snd_is_imm = insn.imm_form.imm_bit;

	assign shift_type = insn.reg_form.shift_type;
	assign shift_field = {insn.reg_form.shift_hi, insn.reg_form.zero_bit};
	assign snd_shift_by_reg = ~snd_is_imm & insn.reg_form.by_reg;
	assign undefined = snd_shift_by_reg & insn.reg_form.zero_bit; // Bit 7 must be zero here.

	always_comb begin
		case (op)
			arm_dp_pkg::alu_tst,
			arm_dp_pkg::alu_teq,
			arm_dp_pkg::alu_cmp,
			arm_dp_pkg::alu_cmn:
				writeback = 1'b0;
			default:
				writeback = 1'b1;
		endcase
	end

	// With rd = R15 the S bit brings back the saved flags instead.
	assign restore_spsr = insn.imm_form.s_bit & (rd == arm_dp_pkg::r15);
	assign update_flags = insn.imm_form.s_bit & ~restore_spsr;

	always_comb begin
		shl = 1'b0;
		shr = 1'b1;
		ror = snd_is_imm;
		put_carry = 1'b0;
		sign_extend = 1'b0;
		imm8 = '0;
		rm = '0;
		rs = '0;

		if (snd_is_imm) begin
			imm8 = insn.imm_form.imm8;
			shift_imm = {1'b0, insn.imm_form.rotate, 1'b0}; // Rotate by twice the field.
		end else begin
			rm = insn.reg_form.rm;
			rs = insn.reg_form.shift_hi;
			shift_imm = {1'b0, shift_field};

			case (shift_type)
				arm_dp_pkg::shift_lsl: begin
					shl = 1'b1;
					shr = 1'b0;
				end
				arm_dp_pkg::shift_asr: sign_extend = 1'b1;
				default: ;
			endcase

			if (!snd_shift_by_reg && shift_field == 5'd0) begin
				case (shift_type)
					arm_dp_pkg::shift_lsr,
					arm_dp_pkg::shift_asr:
						shift_imm = 6'd32; // A zero field means a full-width shift.
					arm_dp_pkg::shift_ror: begin
						// RRX is a one-bit right shift that brings C in at the top.
						shift_imm = 6'd1;
						put_carry = 1'b1;
					end
					default: ;
				endcase
			end else if (shift_type == arm_dp_pkg::shift_ror) begin
				ror = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/dp_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module dp_regfile (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic [arm_dp_pkg::reg_w-1:0]  rd_a,
	input  logic [arm_dp_pkg::reg_w-1:0]  rd_b,
	input  logic [arm_dp_pkg::reg_w-1:0]  rd_c,
	input  logic                          we,
	input  logic [arm_dp_pkg::reg_w-1:0]  wr_addr,
	input  logic [arm_dp_pkg::word_w-1:0] wr_data,
	output logic [arm_dp_pkg::word_w-1:0] data_a,
	output logic [arm_dp_pkg::word_w-1:0] data_b,
	output logic [arm_dp_pkg::word_w-1:0] data_c
);

	localparam int n_regs = 2 ** arm_dp_pkg::reg_w;

	logic [arm_dp_pkg::word_w-1:0] regs [n_regs];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < n_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Reads bypass nothing; a write shows up after the edge.
	assign data_a = regs[rd_a];
	assign data_b = regs[rd_b];
	assign data_c = regs[rd_c];

endmodule

`default_nettype wire

//--- hdl/dp_shifter.sv
`timescale 1ns/1ns
`default_nettype none

module dp_shifter (
	input  logic [arm_dp_pkg::word_w-1:0] value,
	input  logic [7:0]                    imm8,
	input  logic                          snd_is_imm,
	input  logic                          snd_shift_by_reg,
	input  logic [5:0]                    shift_imm,
	input  logic [7:0]                    shift_reg,
	input  logic                          shl,
	input  logic                          shr,
	input  logic                          ror,
	input  logic                          put_carry,
	input  logic                          sign_extend,
	input  logic                          carry_in,
	output logic [arm_dp_pkg::word_w-1:0] operand,
	output logic                          carry_out
);

	localparam int w = arm_dp_pkg::word_w;

	logic [7:0]     amount;
	logic [w-1:0]   rot_src;
	logic [2*w-1:0] rot_wide;
	logic [w:0]     lsl_wide;
	logic [2*w:0]   lsr_wide;
	logic           fill;

	assign amount = snd_shift_by_reg ? shift_reg : {2'b00, shift_imm};
	assign rot_src = snd_is_imm ? {{(w-8){1'b0}}, imm8} : value;

	// Doubling the word turns a right shift into a rotate.
	assign rot_wide = {rot_src, rot_src} >> amount[4:0];
	assign lsl_wide = {1'b0, value} << amount[4:0];

	// For RRX the carry is the fill bit.
	assign fill = put_carry ? carry_in : (sign_extend & value[w-1]);
	assign lsr_wide = {{w{fill}}, value, 1'b0} >> amount[4:0]; // Bit 0 catches the last bit out.

	always_comb begin
		operand = value;
		carry_out = carry_in;

		if (snd_is_imm || ror) begin
			operand = rot_wide[w-1:0]; // A multiple of 32 gives the value unchanged.
			if (amount != 8'd0) begin
				carry_out = rot_wide[w-1];
			end
		end else if (amount == 8'd0) begin
			operand = value;
		end else if (shl) begin
			if (amount < 8'd32) begin
				operand = lsl_wide[w-1:0];
				carry_out = lsl_wide[w];
			end else begin
				operand = '0;
				carry_out = (amount == 8'd32) & value[0];
			end
		end else if (shr) begin
			if (amount < 8'd32) begin
				operand = lsr_wide[w:1];
				carry_out = lsr_wide[0];
			end else begin
				operand = {w{fill}};
				carry_out = (amount == 8'd32) ? value[w-1] : fill;
			end
		end
	end

	a_imm_amount: assert property (@(shift_imm) shift_imm <= 6'd32)
		else $error("Immediate shift amount above 32.");

endmodule

`default_nettype wire

//--- hdl/dp_alu.sv
`timescale 1ns/1ns
`default_nettype none

module dp_alu (
	input  logic [3:0]                    op,
	input  logic [arm_dp_pkg::word_w-1:0] a,
	input  logic [arm_dp_pkg::word_w-1:0] b,
	input  logic                          carry_in,
	input  logic                          shift_carry,
	input  logic                          overflow_in,
	output logic [arm_dp_pkg::word_w-1:0] result,
	output logic [3:0]                    flags_nzcv
);

	localparam int w = arm_dp_pkg::word_w;

	logic [w-1:0] add_x;
	logic [w-1:0] add_y;
	logic         add_cin;
	logic         arith;
	logic [w:0]   sum;
	logic         flag_c;
	logic         flag_v;

	// Every arithmetic opcode maps onto one adder.
	always_comb begin
		add_x = a;
		add_y = b;
		add_cin = 1'b0;
		arith = 1'b1;

		case (op)
			arm_dp_pkg::alu_sub,
			arm_dp_pkg::alu_cmp: begin
				add_y = ~b;
				add_cin = 1'b1;
			end
			arm_dp_pkg::alu_rsb: begin
				add_x = b;
				add_y = ~a;
				add_cin = 1'b1;
			end
			arm_dp_pkg::alu_add,
			arm_dp_pkg::alu_cmn: ;
			arm_dp_pkg::alu_adc: add_cin = carry_in;
			arm_dp_pkg::alu_sbc: begin
				add_y = ~b;
				add_cin = carry_in; // Borrow is the inverted carry.
			end
			arm_dp_pkg::alu_rsc: begin
				add_x = b;
				add_y = ~a;
				add_cin = carry_in;
			end
			default: arith = 1'b0;
		endcase
	end

	assign sum = {1'b0, add_x} + {1'b0, add_y} + {{w{1'b0}}, add_cin};

	always_comb begin
		case (op)
			arm_dp_pkg::alu_and,
			arm_dp_pkg::alu_tst: result = a & b;
			arm_dp_pkg::alu_eor,
			arm_dp_pkg::alu_teq: result = a ^ b;
			arm_dp_pkg::alu_orr: result = a | b;
			arm_dp_pkg::alu_mov: result = b;
			arm_dp_pkg::alu_bic: result = a & ~b;
			arm_dp_pkg::alu_mvn: result = ~b;
			default:             result = sum[w-1:0];
		endcase
	end

	assign flag_c = arith ? sum[w] : shift_carry;
	// Overflow when both addends agree in sign and the sum does not.
	assign flag_v = arith ? ((add_x[w-1] == add_y[w-1]) && (sum[w-1] != add_x[w-1]))
	                      : overflow_in;

	assign flags_nzcv = {result[w-1], result == '0, flag_c, flag_v};

endmodule

`default_nettype wire

//--- hdl/dp_execute_top.sv
`timescale 1ns/1ns
`default_nettype none

module dp_execute_top (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic                          insn_valid,
	input  arm_dp_pkg::dp_insn_u          insn,
	input  logic [3:0]                    spsr_flags,
	output logic                          result_valid,
	output logic [arm_dp_pkg::word_w-1:0] result,
	output logic [arm_dp_pkg::reg_w-1:0]  result_rd,
	output logic                          result_written,
	output logic                          undef,
	output logic [3:0]                    flags
);

	localparam int w = arm_dp_pkg::word_w;
	localparam int rw = arm_dp_pkg::reg_w;

	logic [3:0]    op;
	logic [rw-1:0] rn;
	logic [rw-1:0] rd;
	logic [rw-1:0] rm;
	logic [rw-1:0] rs;
	logic          snd_is_imm;
	logic          snd_shift_by_reg;
	logic [7:0]    imm8;
	logic [5:0]    shift_imm;
	logic          shl;
	logic          shr;
	logic          ror;
	logic          put_carry;
	logic          sign_extend;
	logic          writeback;
	logic          update_flags;
	logic          restore_spsr;
	logic          undefined;
	logic [w-1:0]  rn_value;
	logic [w-1:0]  rm_value;
	logic [w-1:0]  rs_value;
	logic [w-1:0]  operand2;
	logic          shift_carry;
	logic [w-1:0]  alu_result;
	logic [3:0]    alu_flags;
	logic          reg_we;
	logic          accept;

	assign accept = insn_valid & ~undefined;
	assign reg_we = accept & writeback;

	dp_decode u_dp_decode (
		.insn             (insn),
		.op               (op),
		.rn               (rn),
		.rd               (rd),
		.rm               (rm),
		.rs               (rs),
		.snd_is_imm       (snd_is_imm),
		.snd_shift_by_reg (snd_shift_by_reg),
		.imm8             (imm8),
		.shift_imm        (shift_imm),
		.shl              (shl),
		.shr              (shr),
		.ror              (ror),
		.put_carry        (put_carry),
		.sign_extend      (sign_extend),
		.writeback        (writeback),
		.update_flags     (update_flags),
		.restore_spsr     (restore_spsr),
		.undefined        (undefined)
	);

	dp_regfile u_dp_regfile (
		.clk     (clk),
		.arst_n  (arst_n),
		.rd_a    (rn),
		.rd_b    (rm),
		.rd_c    (rs),
		.we      (reg_we),
		.wr_addr (rd),
		.wr_data (alu_result),
		.data_a  (rn_value),
		.data_b  (rm_value),
		.data_c  (rs_value)
	);

	dp_shifter u_dp_shifter (
		.value            (rm_value),
		.imm8             (imm8),
		.snd_is_imm       (snd_is_imm),
		.snd_shift_by_reg (snd_shift_by_reg),
		.shift_imm        (shift_imm),
		.shift_reg        (rs_value[7:0]), // Only the low byte of Rs counts.
		.shl              (shl),
		.shr              (shr),
		.ror              (ror),
		.put_carry        (put_carry),
		.sign_extend      (sign_extend),
		.carry_in         (flags[1]),
		.operand          (operand2),
		.carry_out        (shift_carry)
	);

	dp_alu u_dp_alu (
		.op          (op),
		.a           (rn_value),
		.b           (operand2),
		.carry_in    (flags[1]),
		.shift_carry (shift_carry),
		.overflow_in (flags[0]),
		.result      (alu_result),
		.flags_nzcv  (alu_flags)
	);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			flags <= 4'b0000;
			result_valid <= 1'b0;
			result_written <= 1'b0;
			undef <= 1'b0;
		end else begin
			if (accept && restore_spsr) begin
				flags <= spsr_flags;
			end else if (accept && update_flags) begin
				flags <= alu_flags;
			end
			result_valid <= insn_valid;
			result_written <= reg_we;
			undef <= insn_valid & undefined;
		end
	end

	always_ff @(posedge clk) begin
		result <= alu_result;
		result_rd <= rd;
	end

	a_insn_known: assert property (@(posedge clk) disable iff (!arst_n)
		insn_valid |-> !$isunknown(insn))
		else $error("Instruction word has unknown bits while insn_valid is high.");

endmodule

`default_nettype wire

//--- verification/dp_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module dp_clock_gen #(
	parameter int period = 40,
	parameter int reset_cycles = 8
) (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	initial begin
		arst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		arst_n <= 1'b1; // Released on an edge, like the other inputs.
	end

endmodule

`default_nettype wire

//--- verification/dp_execute_tb.sv
`timescale 1ns/1ns
`default_nettype none

module dp_execute_tb;

	localparam int clk_period = 40;
	localparam int max_rows = 32;

	logic                          clk;
	logic                          arst_n;
	logic                          insn_valid;
	arm_dp_pkg::dp_insn_u          insn;
	logic [3:0]                    spsr_flags;
	logic                          result_valid;
	logic [arm_dp_pkg::word_w-1:0] result;
	logic [arm_dp_pkg::reg_w-1:0]  result_rd;
	logic                          result_written;
	logic                          undef;
	logic [3:0]                    flags;

	arm_dp_pkg::dp_insn_u          row_insn [max_rows];
	logic [3:0]                    row_spsr [max_rows];
	logic [arm_dp_pkg::word_w-1:0] exp_result [max_rows];
	logic                          exp_written [max_rows];
	logic                          exp_undef [max_rows];
	logic [3:0]                    exp_flags [max_rows];
	int                            n_rows = 0;
	int                            n_checked = 0;
	logic                          table_ready = 1'b0;
	logic                          issued = 1'b0;
	integer                        seed = 32'hf334_5504;

	dp_clock_gen #(.period(clk_period), .reset_cycles(8)) u_dp_clock_gen (
		.clk    (clk),
		.arst_n (arst_n)
	);

	dp_execute_top u_dp_execute_top (
		.clk            (clk),
		.arst_n         (arst_n),
		.insn_valid     (insn_valid),
		.insn           (insn),
		.spsr_flags     (spsr_flags),
		.result_valid   (result_valid),
		.result         (result),
		.result_rd      (result_rd),
		.result_written (result_written),
		.undef          (undef),
		.flags          (flags)
	);

	function automatic arm_dp_pkg::dp_insn_u imm_insn(logic [3:0] op, int s, int rd, int rn,
			int rot, int imm);
		return {4'he, 2'b00, 1'b1, op, 1'(s), 4'(rn), 4'(rd), 4'(rot), 8'(imm)};
	endfunction

	function automatic arm_dp_pkg::dp_insn_u shift_insn(logic [3:0] op, int s, int rd, int rn,
			int rm, int typ, int amt);
		return {4'he, 2'b00, 1'b0, op, 1'(s), 4'(rn), 4'(rd), 5'(amt), 2'(typ), 1'b0, 4'(rm)};
	endfunction

	function automatic arm_dp_pkg::dp_insn_u rs_insn(logic [3:0] op, int s, int rd, int rn,
			int rm, int typ, int rs, int bad);
		return {4'he, 2'b00, 1'b0, op, 1'(s), 4'(rn), 4'(rd), 4'(rs), 1'(bad), 2'(typ), 1'b1,
			4'(rm)};
	endfunction

	task automatic add_row(arm_dp_pkg::dp_insn_u i, int spsr, logic [31:0] res, int wr,
			int ud, int fl);
		row_insn[n_rows] = i;
		row_spsr[n_rows] = 4'(spsr);
		exp_result[n_rows] = res;
		exp_written[n_rows] = 1'(wr);
		exp_undef[n_rows] = 1'(ud);
		exp_flags[n_rows] = 4'(fl);
		n_rows++;
	endtask

	// Shift types are 0 LSL, 1 LSR, 2 ASR, 3 ROR; flags are NZCV.
	task automatic build_table();
		add_row(imm_insn(arm_dp_pkg::alu_mov, 0, 1, 0, 4, 'hff), 0, 32'hff00_0000, 1, 0, 'h0);
		add_row(imm_insn(arm_dp_pkg::alu_mov, 1, 2, 0, 1, 'h03), 0, 32'hc000_0000, 1, 0, 'ha);
		add_row(imm_insn(arm_dp_pkg::alu_mvn, 1, 3, 0, 0, 'hff), 0, 32'hffff_ff00, 1, 0, 'ha);
		add_row(imm_insn(arm_dp_pkg::alu_mov, 0, 4, 0, 0, 'h01), 0, 32'h0000_0001, 1, 0, 'ha);
		add_row(imm_insn(arm_dp_pkg::alu_mov, 0, 7, 0, 1, 'h06), 0, 32'h8000_0001, 1, 0, 'ha);
		add_row(imm_insn(arm_dp_pkg::alu_mov, 0, 1, 0, 15, 'h42), 0, 32'h0000_0108, 1, 0, 'ha);
		// Amount 0 with LSR, ASR and ROR gives LSR #32, ASR #32 and RRX.
		add_row(shift_insn(arm_dp_pkg::alu_add, 1, 8, 4, 7, 0, 1), 0, 32'h0000_0003, 1, 0, 'h0);
		add_row(shift_insn(arm_dp_pkg::alu_sub, 1, 9, 4, 4, 0, 0), 0, 32'h0000_0000, 1, 0, 'h6);
		add_row(shift_insn(arm_dp_pkg::alu_rsb, 1, 10, 7, 4, 1, 0), 0, 32'h7fff_ffff, 1, 0, 'h0);
		add_row(shift_insn(arm_dp_pkg::alu_add, 1, 11, 4, 7, 2, 0), 0, 32'h0000_0000, 1, 0, 'h6);
		add_row(shift_insn(arm_dp_pkg::alu_adc, 1, 12, 4, 7, 3, 0), 0, 32'hc000_0002, 1, 0, 'h8);
		add_row(shift_insn(arm_dp_pkg::alu_sbc, 1, 13, 7, 4, 0, 4), 0, 32'h7fff_fff0, 1, 0, 'h3);
		add_row(shift_insn(arm_dp_pkg::alu_rsc, 1, 14, 4, 8, 0, 0), 0, 32'h0000_0002, 1, 0, 'h2);
		add_row(imm_insn(arm_dp_pkg::alu_mov, 0, 2, 0, 0, 'h20), 0, 32'h0000_0020, 1, 0, 'h2);
		add_row(imm_insn(arm_dp_pkg::alu_mov, 0, 3, 0, 0, 'h28), 0, 32'h0000_0028, 1, 0, 'h2);
		// Shift amounts 8, 32, 40 and 0 come from r1, r2, r3 and r5.
		add_row(rs_insn(arm_dp_pkg::alu_mov, 1, 8, 0, 7, 0, 1, 0), 0, 32'h0000_0100, 1, 0, 'h0);
		add_row(rs_insn(arm_dp_pkg::alu_mov, 1, 9, 0, 7, 1, 2, 0), 0, 32'h0000_0000, 1, 0, 'h6);
		add_row(rs_insn(arm_dp_pkg::alu_mov, 1, 10, 0, 7, 2, 3, 0), 0, 32'hffff_ffff, 1, 0, 'ha);
		add_row(rs_insn(arm_dp_pkg::alu_mov, 1, 11, 0, 7, 3, 5, 0), 0, 32'h8000_0001, 1, 0, 'ha);
		add_row(rs_insn(arm_dp_pkg::alu_mov, 1, 6, 0, 7, 0, 3, 0), 0, 32'h0000_0000, 1, 0, 'h4);
		// Compares name a live register as rd; the MOV after them reads it back.
		add_row(shift_insn(arm_dp_pkg::alu_cmp, 1, 4, 4, 8, 0, 0), 0, 32'hffff_ff01, 0, 0, 'h8);
		add_row(shift_insn(arm_dp_pkg::alu_cmn, 1, 10, 10, 4, 0, 0), 0, 32'h0000_0000, 0, 0, 'h6);
		add_row(imm_insn(arm_dp_pkg::alu_tst, 1, 7, 7, 1, 'h02), 0, 32'h8000_0000, 0, 0, 'ha);
		add_row(shift_insn(arm_dp_pkg::alu_teq, 1, 11, 11, 11, 0, 0), 0, 32'h0000_0000, 0, 0, 'h6);
		add_row(shift_insn(arm_dp_pkg::alu_mov, 0, 0, 0, 4, 0, 0), 0, 32'h0000_0001, 1, 0, 'h6);
		add_row(imm_insn(arm_dp_pkg::alu_mov, 1, 15, 0, 0, 'h11), 9, 32'h0000_0011, 1, 0, 'h9);
		add_row(imm_insn(arm_dp_pkg::alu_add, 0, 15, 4, 0, 'h01), 5, 32'h0000_0002, 1, 0, 'h9);
		add_row(rs_insn(arm_dp_pkg::alu_add, 1, 6, 4, 7, 0, 1, 1), 0, 32'h0000_0101, 0, 1, 'h9);
		add_row(shift_insn(arm_dp_pkg::alu_mov, 0, 0, 0, 6, 0, 0), 0, 32'h0000_0000, 1, 0, 'h9);
	endtask

	task automatic stop_run();
		$display("Errors found");
		$fatal(1, "Simulation stopped at the first failure.");
	endtask

	task automatic check_word(string name, logic [arm_dp_pkg::word_w-1:0] got,
			logic [arm_dp_pkg::word_w-1:0] exp);
		if (got !== exp) begin
			$display("Error: %s is %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_reg(string name, logic [arm_dp_pkg::reg_w-1:0] got,
			logic [arm_dp_pkg::reg_w-1:0] exp);
		if (got !== exp) begin
			$display("Error: %s is %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_flags(string name, logic [3:0] got, logic [3:0] exp);
		if (got !== exp) begin
			$display("Error: %s is %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("Error: %s is %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	always @(posedge clk) begin
		issued <= insn_valid; // The value that the DUT samples at this edge.
	end

	always @(negedge clk) begin
		if (arst_n) begin
			if (result_valid !== issued) begin
				$display("A result_valid pulse was missing or came without an instruction.");
				stop_run();
			end
			if (issued) begin
				check_word("result", result, exp_result[n_checked]);
				check_reg("result_rd", result_rd, row_insn[n_checked].imm_form.rd);
				check_bit("result_written", result_written, exp_written[n_checked]);
				check_bit("undef", undef, exp_undef[n_checked]);
				check_flags("flags", flags, exp_flags[n_checked]);
				n_checked++;
			end
		end
	end

	initial begin
		wait (table_ready);
		#((n_rows * 3 + 100) * clk_period);
		$display("Results stopped arriving before every instruction was checked.");
		stop_run();
	end

	initial begin
		int idle;
		insn_valid = 1'b0;
		insn = '0;
		spsr_flags = 4'h0;
		build_table();
		table_ready = 1'b1;
		wait (arst_n);
		for (int i = 0; i < n_rows; i++) begin
			@(posedge clk);
			insn_valid <= 1'b1;
			insn <= row_insn[i];
			spsr_flags <= row_spsr[i];
			if (i % 6 == 5) begin
				idle = 1 + ($unsigned($random(seed)) % 3);
				repeat (idle) begin
					@(posedge clk);
					insn_valid <= 1'b0;
				end
			end
		end
		@(posedge clk);
		insn_valid <= 1'b0;
		wait (n_checked == n_rows);
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
hdl/arm_dp_pkg.sv
hdl/dp_decode.sv
hdl/dp_regfile.sv
hdl/dp_shifter.sv
hdl/dp_alu.sv
hdl/dp_execute_top.sv
verification/dp_clock_gen.sv
verification/dp_execute_tb.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it. A $fatal in the run gives a non-zero exit.
cd "$(dirname "$0")" \
	&& verilator --binary --assert --top-module dp_execute_tb -f compile.f -o dp_execute_tb \
	&& ./obj_dir/dp_execute_tb \
	|| exit 1
